// ==== rv_ex.f ====
+incdir+src
src/rv_ex_pkg.sv
src/alu.sv
src/fwd_unit.sv
src/execute.sv
src/ex_mem_reg.sv
src/rv_ex_top.sv
dv/rv_ex_tb.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: run clean

run: obj_dir/Vrv_ex_tb
	./obj_dir/Vrv_ex_tb

obj_dir/Vrv_ex_tb: rv_ex.f $(SRCS)
	verilator --binary --timing --assert -f rv_ex.f --top-module rv_ex_tb -o Vrv_ex_tb

clean:
	rm -rf obj_dir

// ==== dv/rv_ex_tb.sv ====
`include "rv_ex_settings.svh"

module rv_ex_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_ex_pkg::*;

    localparam int NUM_RANDOM = 200;
    localparam int NUM_TABLE  = 25;

    // One decoded instruction plus the later-stage inputs seen with it
    typedef struct {
        logic                      valid;
        op_class_t                 cls;
        alu_ctrl_t                 ctrl;
        logic                      src;     // alu_src
        logic [`RV_EX_RADDR_W-1:0] rs1a;
        logic [`RV_EX_XLEN-1:0]    rs1v;
        logic [`RV_EX_RADDR_W-1:0] rs2a;
        logic [`RV_EX_XLEN-1:0]    rs2v;
        logic [`RV_EX_XLEN-1:0]    imm;
        logic [`RV_EX_XLEN-1:0]    pc;
        logic [`RV_EX_RADDR_W-1:0] rd;
        logic [5:0]                ctl;     // reg_write mem_write mem_read mem_to_reg branch pc_src
        logic                      mwe;
        logic [`RV_EX_RADDR_W-1:0] mrd;
        logic [`RV_EX_XLEN-1:0]    mval;
        logic                      we;
        logic [`RV_EX_RADDR_W-1:0] wa;
        logic [`RV_EX_XLEN-1:0]    wv;
        logic [`RV_EX_XLEN-1:0]    e_res;
        logic                      e_zero;
        logic [`RV_EX_XLEN-1:0]    e_store;
    } row_t;

    logic clk;
    logic rst;
    logic                      id_valid;
    logic [`RV_EX_RADDR_W-1:0] rs1_addr;
    logic [`RV_EX_RADDR_W-1:0] rs2_addr;
    logic [`RV_EX_XLEN-1:0]    rs1_value;
    logic [`RV_EX_XLEN-1:0]    rs2_value;
    logic [`RV_EX_XLEN-1:0]    imm;
    logic [`RV_EX_XLEN-1:0]    pc;
    logic                      alu_src;
    op_class_t                 op_class;
    alu_ctrl_t                 alu_ctrl;
    logic                      mem_write;
    logic                      mem_read;
    logic                      reg_write;
    logic [`RV_EX_RADDR_W-1:0] rd_addr;
    logic                      mem_to_reg;
    logic                      branch;
    logic                      pc_src;
    logic                      mem_wb_reg_write;
    logic [`RV_EX_RADDR_W-1:0] mem_wb_rd;
    logic [`RV_EX_XLEN-1:0]    mem_wb_value;
    logic                      wb_en;
    logic [`RV_EX_RADDR_W-1:0] wb_addr;
    logic [`RV_EX_XLEN-1:0]    wb_value;
    logic                      em_valid;
    logic [`RV_EX_XLEN-1:0]    em_result;
    logic [`RV_EX_XLEN-1:0]    em_store_data;
    logic                      em_zero;
    logic                      em_mem_write;
    logic                      em_mem_read;
    logic                      em_reg_write;
    logic [`RV_EX_RADDR_W-1:0] em_rd;
    logic                      em_mem_to_reg;
    logic                      em_branch;
    logic                      em_pc_src;

    row_t tbl [NUM_TABLE];
    row_t rows [$];           // Table rows then random rows, in issue order
    logic [31:0] seed;

    rv_ex_top u_rv_ex_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [`RV_EX_XLEN-1:0] alu_ref(input alu_ctrl_t c,
                                                       input logic [`RV_EX_XLEN-1:0] a,
                                                       input logic [`RV_EX_XLEN-1:0] b);
        case (c)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_SLTU: return (a < b) ? 1 : 0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return '0;
        endcase
    endfunction

    // Forwarded operand for row i with row i-2 still sitting in EX/MEM
    function automatic logic [`RV_EX_XLEN-1:0] fwd_ref(input int i, input row_t r,
                                                       input logic [`RV_EX_RADDR_W-1:0] a,
                                                       input logic [`RV_EX_XLEN-1:0] rf);
        row_t p;
        if (a == `RV_EX_ZERO_REG)
            return rf;
        if (i >= 2)
        begin
            p = rows[i-2];
            if (p.valid && p.ctl[5] && p.rd == a)
                return p.e_res;
        end
        if (r.mwe && r.mrd == a)
            return r.mval;
        if (r.we && r.wa == a)
            return r.wv;
        return rf;
    endfunction

    task automatic load_table();
        // valid cls ctrl src rs1a rs1v rs2a rs2v imm pc / rd ctl mwe mrd mval we wa wv / res z st
        tbl[0]  = '{1, CLS_RI, ALU_ADD, 0, 1, 'h5, 2, 'h7, 0, 0,
                    3, 0, 0, 0, 0, 0, 0, 0, 'hc, 0, 'h7};
        tbl[1]  = '{1, CLS_RI, ALU_SUB, 0, 1, 'h7, 2, 'h7, 0, 0,
                    3, 0, 0, 0, 0, 0, 0, 0, 0, 1, 'h7};
        tbl[2]  = '{1, CLS_RI, ALU_SLL, 1, 1, 'h1, 2, 'h20, 'h24, 0,   // Shift uses imm[4:0]
                    0, 0, 0, 0, 0, 0, 0, 0, 'h10, 0, 'h20};
        tbl[3]  = '{1, CLS_RI, ALU_SLT, 0, 1, 'hffffffff, 2, 'h1, 0, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 'h1, 0, 'h1};
        tbl[4]  = '{1, CLS_RI, ALU_SLTU, 0, 1, 'hffffffff, 2, 'h1, 0, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 'h1};
        tbl[5]  = '{1, CLS_RI, ALU_XOR, 1, 1, 'hf0f0f0f0, 2, 'h3, 'h0ff00ff0, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 'hff00ff00, 0, 'h3};
        tbl[6]  = '{1, CLS_RI, ALU_SRL, 1, 1, 'h80000000, 2, 0, 'h4, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 'h08000000, 0, 0};
        tbl[7]  = '{1, CLS_RI, ALU_SRA, 1, 1, 'h80000000, 2, 0, 'h4, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 'hf8000000, 0, 0};
        tbl[8]  = '{1, CLS_RI, ALU_OR, 0, 1, 'h00ff0000, 2, 'hff, 0, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 'h00ff00ff, 0, 'hff};
        tbl[9]  = '{1, CLS_RI, ALU_AND, 0, 1, 'h0f0f, 2, 'hff, 0, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 'hf, 0, 'hff};
        tbl[10] = '{1, CLS_LDST, ALU_ADD, 0, 1, 'h1000, 6, 'habcd, 'h10, 0,   // Load to x5
                    5, 'h2c, 0, 0, 0, 0, 0, 0, 'h1010, 0, 'habcd};
        tbl[11] = '{1, CLS_LDST, ALU_ADD, 0, 1, 'h2000, 6, 'h55, 'h8, 0,
                    0, 'h10, 0, 0, 0, 0, 0, 0, 'h2008, 0, 'h55};
        tbl[12] = '{1, CLS_RI, ALU_ADD, 0, 5, 'hdead, 7, 'h1, 0, 0,      // All three hit, EX/MEM wins
                    8, 'h20, 1, 5, 'h111, 1, 5, 'h222, 'h1011, 0, 'h1};
        tbl[13] = '{1, CLS_RI, ALU_ADD, 0, 5, 'hdead, 9, 0, 0, 0,        // MEM/WB over write port
                    9, 'h20, 1, 5, 'h111, 1, 5, 'h222, 'h111, 0, 0};
        tbl[14] = '{1, CLS_RI, ALU_ADD, 0, 10, 'hdead, 8, 'hbeef, 0, 0,
                    0, 'h20, 0, 10, 'h111, 1, 10, 'h333, 'h1344, 0, 'h1011};
        tbl[15] = '{1, CLS_RI, ALU_SUB, 0, 9, 'h1, 9, 'h2, 0, 0,
                    0, 'h20, 0, 0, 0, 0, 0, 0, 0, 1, 'h111};
        tbl[16] = '{1, CLS_RI, ALU_ADD, 0, 0, 0, 0, 0, 0, 0,             // Everything aims at x0
                    0, 'h20, 1, 0, 'h999, 1, 0, 'h888, 0, 1, 0};
        tbl[17] = '{1, CLS_RI, ALU_OR, 0, 0, 0, 0, 0, 0, 0,
                    0, 0, 1, 0, 'h999, 1, 0, 'h888, 0, 1, 0};
        tbl[18] = '{1, CLS_LUI, ALU_ADD, 0, 20, 'h77, 21, 'h5, 'h12345000, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 'h12345000, 0, 'h5};
        tbl[19] = '{1, CLS_AUIPC, ALU_ADD, 0, 20, 'h77, 21, 0, 'h1000, 'h400,
                    0, 0, 0, 0, 0, 0, 0, 0, 'h1400, 0, 0};
        tbl[20] = '{1, CLS_JAL, ALU_ADD, 0, 20, 0, 21, 0, 'h20, 'h800,
                    1, 'h20, 0, 0, 0, 0, 0, 0, 'h820, 0, 0};
        tbl[21] = '{1, CLS_JALR, ALU_ADD, 0, 22, 'h5000, 21, 0, 'h4, 'h900,
                    1, 'h21, 0, 0, 0, 0, 0, 0, 'h904, 0, 0};
        tbl[22] = '{1, CLS_BRANCH, ALU_SUB, 0, 11, 'h42, 12, 'h42, 0, 0,
                    0, 'h03, 0, 0, 0, 0, 0, 0, 0, 1, 'h42};
        tbl[23] = '{0, CLS_RI, ALU_ADD, 0, 13, 'h3, 14, 'h4, 0, 0,       // Bubble
                    2, 'h33, 0, 0, 0, 0, 0, 0, 'h7, 0, 'h4};
        tbl[24] = '{1, op_class_t'(3'b110), ALU_ADD, 0, 15, 'h9, 16, 'h9, 0, 0,
                    0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 'h9};
        for (int k = 0; k < NUM_TABLE; k++)
            rows.push_back(tbl[k]);
    endtask

    task automatic gen_random();
        row_t r;
        logic [`RV_EX_XLEN-1:0] a;
        logic [`RV_EX_XLEN-1:0] b2;
        for (int k = 0; k < NUM_RANDOM; k++)
        begin
            seed    = xorshift(seed);
            r.valid = (seed[3:0] != 4'd0);
            r.cls   = CLS_RI;
            r.ctrl  = alu_ctrl_t'(4'(seed[11:4] % 8'd10));
            r.src   = seed[12];
            r.rs1a  = {3'b000, seed[14:13]};   // Narrow range so hits are common
            r.rs2a  = {3'b000, seed[16:15]};
            r.rd    = {3'b000, seed[18:17]};
            r.ctl   = {seed[19], 5'b00000};
            r.mwe   = seed[20];
            r.mrd   = {3'b000, seed[22:21]};
            r.we    = seed[23];
            r.wa    = {3'b000, seed[25:24]};
            r.pc    = '0;
            seed    = xorshift(seed);
            r.rs1v  = seed;
            seed    = xorshift(seed);
            r.rs2v  = seed;
            seed    = xorshift(seed);
            r.imm   = seed;
            seed    = xorshift(seed);
            r.mval  = seed;
            seed    = xorshift(seed);
            r.wv    = seed;
            a         = fwd_ref(rows.size(), r, r.rs1a, r.rs1v);
            b2        = fwd_ref(rows.size(), r, r.rs2a, r.rs2v);
            r.e_res   = alu_ref(r.ctrl, a, r.src ? r.imm : b2);
            r.e_zero  = (r.e_res == '0);
            r.e_store = b2;
            rows.push_back(r);
        end
    endtask

    task automatic apply_row(input row_t r);
        id_valid         = r.valid;
        rs1_addr         = r.rs1a;
        rs2_addr         = r.rs2a;
        rs1_value        = r.rs1v;
        rs2_value        = r.rs2v;
        imm              = r.imm;
        pc               = r.pc;
        alu_src          = r.src;
        op_class         = r.cls;
        alu_ctrl         = r.ctrl;
        {reg_write, mem_write, mem_read, mem_to_reg, branch, pc_src} = r.ctl;
        rd_addr          = r.rd;
        mem_wb_reg_write = r.mwe;
        mem_wb_rd        = r.mrd;
        mem_wb_value     = r.mval;
        wb_en            = r.we;
        wb_addr          = r.wa;
        wb_value         = r.wv;
    endtask

    task automatic drive_idle();
        row_t r;
        r = '{0, CLS_LDST, ALU_ADD, 0, 0, 0, 0, 0, 0, 0,
              0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        apply_row(r);
    endtask

    task automatic fail_now();
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [`RV_EX_XLEN-1:0] got,
                              input logic [`RV_EX_XLEN-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_ctrl(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_rd(input string name, input logic [`RV_EX_RADDR_W-1:0] got,
                            input logic [`RV_EX_RADDR_W-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_row(input row_t r);
        check_word("em_result", em_result, r.e_res);
        check_word("em_store_data", em_store_data, r.e_store);
        check_ctrl("em_zero", em_zero, r.e_zero);
        check_ctrl("em_valid", em_valid, r.valid);
        check_ctrl("em_reg_write", em_reg_write, r.ctl[5] & r.valid);   // Bubble gates these
        check_ctrl("em_mem_write", em_mem_write, r.ctl[4] & r.valid);
        check_ctrl("em_mem_read", em_mem_read, r.ctl[3] & r.valid);
        check_ctrl("em_mem_to_reg", em_mem_to_reg, r.ctl[2]);
        check_ctrl("em_branch", em_branch, r.ctl[1] & r.valid);
        check_ctrl("em_pc_src", em_pc_src, r.ctl[0] & r.valid);
        check_rd("em_rd", em_rd, r.rd);
    endtask

    initial
    begin
        int cnt;
        seed = 32'h96179b63;
        rst  = 1'b1;
        drive_idle();
        cnt = 0;
        while (cnt < 3 || em_valid !== 1'b0)   // Three rising edges and an idle EX/MEM
        begin
            @(posedge clk);
            cnt++;
            if (cnt > 10)
            begin
                $display("timeout while holding reset");
                fail_now();
            end
        end
        @(negedge clk);
        rst = 1'b0;
        check_ctrl("em_valid", em_valid, 1'b0);
        check_ctrl("em_mem_write", em_mem_write, 1'b0);
        check_ctrl("em_mem_read", em_mem_read, 1'b0);
        check_ctrl("em_reg_write", em_reg_write, 1'b0);
        check_ctrl("em_pc_src", em_pc_src, 1'b0);
        check_word("em_result", em_result, '0);

        load_table();
        gen_random();

        // Row t-2 is visible two rising edges after it was driven
        for (int t = 0; t < rows.size() + 2; t++)
        begin
            @(negedge clk);
            if (t >= 2)
                check_row(rows[t-2]);
            if (t < rows.size())
                apply_row(rows[t]);
            else
                drive_idle();
        end

        cnt = 0;
        while (em_valid)   // Drain the idle rows through
        begin
            @(negedge clk);
            cnt++;
            if (cnt > 8)
            begin
                $display("timeout waiting for the pipeline to drain");
                fail_now();
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== src/rv_ex_top.sv ====
`include "rv_ex_settings.svh"

module rv_ex_top (
    input  logic                      clk,
    input  logic                      rst,
    // Decode
    input  logic                      id_valid,
    input  logic [`RV_EX_RADDR_W-1:0] rs1_addr,
    input  logic [`RV_EX_RADDR_W-1:0] rs2_addr,
    input  logic [`RV_EX_XLEN-1:0]    rs1_value,
    input  logic [`RV_EX_XLEN-1:0]    rs2_value,
    input  logic [`RV_EX_XLEN-1:0]    imm,
    input  logic [`RV_EX_XLEN-1:0]    pc,
    input  logic                      alu_src,
    input  rv_ex_pkg::op_class_t      op_class,
    input  rv_ex_pkg::alu_ctrl_t      alu_ctrl,
    input  logic                      mem_write,
    input  logic                      mem_read,
    input  logic                      reg_write,
    input  logic [`RV_EX_RADDR_W-1:0] rd_addr,
    input  logic                      mem_to_reg,
    input  logic                      branch,
    input  logic                      pc_src,
    // MEM/WB and register file write port
    input  logic                      mem_wb_reg_write,
    input  logic [`RV_EX_RADDR_W-1:0] mem_wb_rd,
    input  logic [`RV_EX_XLEN-1:0]    mem_wb_value,
    input  logic                      wb_en,
    input  logic [`RV_EX_RADDR_W-1:0] wb_addr,
    input  logic [`RV_EX_XLEN-1:0]    wb_value,
    // EX/MEM outputs, two cycles after decode
    output logic                      em_valid,
    output logic [`RV_EX_XLEN-1:0]    em_result,
    output logic [`RV_EX_XLEN-1:0]    em_store_data,
    output logic                      em_zero,
    output logic                      em_mem_write,
    output logic                      em_mem_read,
    output logic                      em_reg_write,
    output logic [`RV_EX_RADDR_W-1:0] em_rd,
    output logic                      em_mem_to_reg,
    output logic                      em_branch,
    output logic                      em_pc_src
);

    logic                      ex_valid;
    logic [`RV_EX_XLEN-1:0]    ex_result;
    logic [`RV_EX_XLEN-1:0]    ex_store_data;
    logic                      ex_zero;
    logic                      ex_mem_write;
    logic                      ex_mem_read;
    logic                      ex_reg_write;
    logic [`RV_EX_RADDR_W-1:0] ex_rd;
    logic                      ex_mem_to_reg;
    logic                      ex_branch;
    logic                      ex_pc_src;

    execute u_execute (
        .clk              (clk),
        .rst              (rst),
        .id_valid         (id_valid),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .rs1_value        (rs1_value),
        .rs2_value        (rs2_value),
        .imm              (imm),
        .pc               (pc),
        .alu_src          (alu_src),
        .op_class         (op_class),
        .alu_ctrl         (alu_ctrl),
        .mem_write        (mem_write),
        .mem_read         (mem_read),
        .reg_write        (reg_write),
        .rd_addr          (rd_addr),
        .mem_to_reg       (mem_to_reg),
        .branch           (branch),
        .pc_src           (pc_src),
        .em_reg_write     (em_reg_write),   // EX/MEM result loops back, highest priority
        .em_rd            (em_rd),
        .em_result        (em_result),
        .mem_wb_reg_write (mem_wb_reg_write),
        .mem_wb_rd        (mem_wb_rd),
        .mem_wb_value     (mem_wb_value),
        .wb_en            (wb_en),
        .wb_addr          (wb_addr),
        .wb_value         (wb_value),
        .ex_valid         (ex_valid),
        .ex_result        (ex_result),
        .ex_store_data    (ex_store_data),
        .ex_zero          (ex_zero),
        .ex_mem_write     (ex_mem_write),
        .ex_mem_read      (ex_mem_read),
        .ex_reg_write     (ex_reg_write),
        .ex_rd            (ex_rd),
        .ex_mem_to_reg    (ex_mem_to_reg),
        .ex_branch        (ex_branch),
        .ex_pc_src        (ex_pc_src)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_zero       (ex_zero),
        .ex_mem_write  (ex_mem_write),
        .ex_mem_read   (ex_mem_read),
        .ex_reg_write  (ex_reg_write),
        .ex_rd         (ex_rd),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_branch     (ex_branch),
        .ex_pc_src     (ex_pc_src),
        .em_valid      (em_valid),
        .em_result     (em_result),
        .em_store_data (em_store_data),
        .em_zero       (em_zero),
        .em_mem_write  (em_mem_write),
        .em_mem_read   (em_mem_read),
        .em_reg_write  (em_reg_write),
        .em_rd         (em_rd),
        .em_mem_to_reg (em_mem_to_reg),
        .em_branch     (em_branch),
        .em_pc_src     (em_pc_src)
    );

endmodule

// ==== src/ex_mem_reg.sv ====
`include "rv_ex_settings.svh"

module ex_mem_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ex_valid,
    input  logic [`RV_EX_XLEN-1:0]    ex_result,
    input  logic [`RV_EX_XLEN-1:0]    ex_store_data,
    input  logic                      ex_zero,
    input  logic                      ex_mem_write,
    input  logic                      ex_mem_read,
    input  logic                      ex_reg_write,
    input  logic [`RV_EX_RADDR_W-1:0] ex_rd,
    input  logic                      ex_mem_to_reg,
    input  logic                      ex_branch,
    input  logic                      ex_pc_src,
    output logic                      em_valid,
    output logic [`RV_EX_XLEN-1:0]    em_result,     // Also the top forwarding source
    output logic [`RV_EX_XLEN-1:0]    em_store_data,
    output logic                      em_zero,
    output logic                      em_mem_write,
    output logic                      em_mem_read,
    output logic                      em_reg_write,
    output logic [`RV_EX_RADDR_W-1:0] em_rd,
    output logic                      em_mem_to_reg,
    output logic                      em_branch,
    output logic                      em_pc_src
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            em_valid      <= 1'b0;
            em_result     <= '0;
            em_store_data <= '0;
            em_zero       <= 1'b0;
            em_mem_write  <= 1'b0;
            em_mem_read   <= 1'b0;
            em_reg_write  <= 1'b0;
            em_rd         <= '0;
            em_mem_to_reg <= 1'b0;
            em_branch     <= 1'b0;
            em_pc_src     <= 1'b0;
        end
        else
        begin
            em_valid      <= ex_valid;
            em_result     <= ex_result;
            em_store_data <= ex_store_data;
            em_zero       <= ex_zero;
            em_mem_write  <= ex_mem_write;
            em_mem_read   <= ex_mem_read;
            em_reg_write  <= ex_reg_write;
            em_rd         <= ex_rd;
            em_mem_to_reg <= ex_mem_to_reg;
            em_branch     <= ex_branch;
            em_pc_src     <= ex_pc_src;
        end
    end

    // Data memory takes one access per instruction
    a_one_mem_op: assert property (
        @(posedge clk) disable iff (rst)
        !(em_mem_read && em_mem_write)
    ) else $error("ex_mem_reg: load and store in the same slot");

endmodule

// ==== src/execute.sv ====
`include "rv_ex_settings.svh"

module execute (
    input  logic                      clk,
    input  logic                      rst,
    // Decode side
    input  logic                      id_valid,
    input  logic [`RV_EX_RADDR_W-1:0] rs1_addr,
    input  logic [`RV_EX_RADDR_W-1:0] rs2_addr,
    input  logic [`RV_EX_XLEN-1:0]    rs1_value,
    input  logic [`RV_EX_XLEN-1:0]    rs2_value,
    input  logic [`RV_EX_XLEN-1:0]    imm,
    input  logic [`RV_EX_XLEN-1:0]    pc,
    input  logic                      alu_src,     // R/I only, 1 selects imm
    input  rv_ex_pkg::op_class_t      op_class,
    input  rv_ex_pkg::alu_ctrl_t      alu_ctrl,
    input  logic                      mem_write,
    input  logic                      mem_read,
    input  logic                      reg_write,
    input  logic [`RV_EX_RADDR_W-1:0] rd_addr,
    input  logic                      mem_to_reg,
    input  logic                      branch,
    input  logic                      pc_src,
    // EX/MEM feedback
    input  logic                      em_reg_write,
    input  logic [`RV_EX_RADDR_W-1:0] em_rd,
    input  logic [`RV_EX_XLEN-1:0]    em_result,
    // Later stages
    input  logic                      mem_wb_reg_write,
    input  logic [`RV_EX_RADDR_W-1:0] mem_wb_rd,
    input  logic [`RV_EX_XLEN-1:0]    mem_wb_value,
    input  logic                      wb_en,
    input  logic [`RV_EX_RADDR_W-1:0] wb_addr,
    input  logic [`RV_EX_XLEN-1:0]    wb_value,
    // Toward EX/MEM
    output logic                      ex_valid,
    output logic [`RV_EX_XLEN-1:0]    ex_result,
    output logic [`RV_EX_XLEN-1:0]    ex_store_data,
    output logic                      ex_zero,
    output logic                      ex_mem_write,
    output logic                      ex_mem_read,
    output logic                      ex_reg_write,
    output logic [`RV_EX_RADDR_W-1:0] ex_rd,
    output logic                      ex_mem_to_reg,
    output logic                      ex_branch,
    output logic                      ex_pc_src
);
    import rv_ex_pkg::*;

    fwd_sel_t                  sel1;
    fwd_sel_t                  sel2;
    logic [`RV_EX_XLEN-1:0]    rs1_fwd;
    logic [`RV_EX_XLEN-1:0]    rs2_fwd;
    logic [`RV_EX_XLEN-1:0]    idex_rs1;
    logic [`RV_EX_XLEN-1:0]    idex_imm;
    logic [`RV_EX_XLEN-1:0]    idex_pc;
    op_class_t                 idex_class;
    logic                      idex_alu_src;
    alu_ctrl_t                 idex_alu_ctrl;
    logic [`RV_EX_XLEN-1:0]    op_a;
    logic [`RV_EX_XLEN-1:0]    op_b;

    fwd_unit u_fwd_unit (
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .em_reg_write     (em_reg_write),
        .em_rd            (em_rd),
        .mem_wb_reg_write (mem_wb_reg_write),
        .mem_wb_rd        (mem_wb_rd),
        .wb_en            (wb_en),
        .wb_addr          (wb_addr),
        .sel1             (sel1),
        .sel2             (sel2)
    );

    // Data side of forwarding, same mux for both operands
    function automatic logic [`RV_EX_XLEN-1:0] fwd_mux(input fwd_sel_t               sel,
                                                       input logic [`RV_EX_XLEN-1:0] rf);
        case (sel)
            FWD_EXMEM:  return em_result;
            FWD_MEMWB:  return mem_wb_value;
            FWD_WRPORT: return wb_value;
            default:    return rf;
        endcase
    endfunction

    always_comb
    begin
        rs1_fwd = fwd_mux(sel1, rs1_value);
        rs2_fwd = fwd_mux(sel2, rs2_value);
    end

    // ID/EX register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_valid      <= 1'b0;
            idex_rs1      <= '0;
            ex_store_data <= '0;
            idex_imm      <= '0;
            idex_pc       <= '0;
            idex_class    <= CLS_LDST;
            idex_alu_src  <= 1'b0;
            idex_alu_ctrl <= ALU_ADD;
            ex_mem_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_rd         <= '0;
            ex_mem_to_reg <= 1'b0;
            ex_branch     <= 1'b0;
            ex_pc_src     <= 1'b0;
        end
        else
        begin
            ex_valid      <= id_valid;
            idex_rs1      <= rs1_fwd;
            ex_store_data <= rs2_fwd;      // Forwarded rs2 doubles as store data
            idex_imm      <= imm;
            idex_pc       <= pc;
            idex_class    <= op_class;
            idex_alu_src  <= alu_src;
            idex_alu_ctrl <= alu_ctrl;
            // Bubble kills anything that changes state downstream
            ex_mem_write  <= mem_write & id_valid;
            ex_mem_read   <= mem_read  & id_valid;
            ex_reg_write  <= reg_write & id_valid;
            ex_branch     <= branch    & id_valid;
            ex_pc_src     <= pc_src    & id_valid;
            ex_rd         <= rd_addr;
            ex_mem_to_reg <= mem_to_reg;
        end
    end

    // Operand pair by class
    always_comb
    begin
        case (idex_class)
            CLS_LDST:   begin op_a = idex_rs1; op_b = idex_imm;      end
            CLS_BRANCH: begin op_a = idex_rs1; op_b = ex_store_data; end
            CLS_RI:
            begin
                op_a = idex_rs1;
                op_b = idex_alu_src ? idex_imm : ex_store_data;
            end
            CLS_LUI:    begin op_a = '0;       op_b = idex_imm;      end
            CLS_AUIPC,
            CLS_JAL,
            CLS_JALR:   begin op_a = idex_pc;  op_b = idex_imm;      end   // Target or link base
            default:    begin op_a = '0;       op_b = '0;            end
        endcase
    end

    alu u_alu (
        .ctrl   (idex_alu_ctrl),
        .a      (op_a),
        .b      (op_b),
        .result (ex_result),
        .zero   (ex_zero)
    );

    // A bubble never reaches EX/MEM with a live control
    a_bubble_quiet: assert property (
        @(posedge clk) disable iff (rst)
        !ex_valid |-> !(ex_mem_write || ex_mem_read || ex_reg_write || ex_branch || ex_pc_src)
    ) else $error("execute: write-type control high on a bubble");

endmodule

// ==== src/fwd_unit.sv ====
`include "rv_ex_settings.svh"

module fwd_unit (
    input  logic [`RV_EX_RADDR_W-1:0] rs1_addr,
    input  logic [`RV_EX_RADDR_W-1:0] rs2_addr,
    input  logic                      em_reg_write,
    input  logic [`RV_EX_RADDR_W-1:0] em_rd,
    input  logic                      mem_wb_reg_write,
    input  logic [`RV_EX_RADDR_W-1:0] mem_wb_rd,
    input  logic                      wb_en,
    input  logic [`RV_EX_RADDR_W-1:0] wb_addr,
    output rv_ex_pkg::fwd_sel_t       sel1,
    output rv_ex_pkg::fwd_sel_t       sel2
);
    import rv_ex_pkg::*;

    // A source matches when it writes, targets a real register and hits rs
    function automatic logic hit(input logic                      we,
                                 input logic [`RV_EX_RADDR_W-1:0] rd,
                                 input logic [`RV_EX_RADDR_W-1:0] rs);
        return we && (rd != `RV_EX_ZERO_REG) && (rd == rs);
    endfunction

    // Fixed priority, newest value first
    function automatic fwd_sel_t pick(input logic [`RV_EX_RADDR_W-1:0] rs);
        fwd_sel_t sel;
        if (hit(em_reg_write, em_rd, rs))
            sel = FWD_EXMEM;
        else if (hit(mem_wb_reg_write, mem_wb_rd, rs))
            sel = FWD_MEMWB;
        else if (hit(wb_en, wb_addr, rs))
            sel = FWD_WRPORT;
        else
            sel = FWD_RF;
        return sel;
    endfunction

    always_comb
    begin
        sel1 = pick(rs1_addr);
        sel2 = pick(rs2_addr);
    end

    // x0 reads zero from the file whatever is in flight
    a_x0_no_fwd: assert property (
        @(posedge execute.clk) disable iff (execute.rst)
        ((rs1_addr == `RV_EX_ZERO_REG) |-> (sel1 == FWD_RF)) and
        ((rs2_addr == `RV_EX_ZERO_REG) |-> (sel2 == FWD_RF))
    ) else $error("fwd_unit: x0 selected a forwarded value");

endmodule

// ==== src/alu.sv ====
`include "rv_ex_settings.svh"

module alu (
    input  rv_ex_pkg::alu_ctrl_t    ctrl,
    input  logic [`RV_EX_XLEN-1:0]  a,
    input  logic [`RV_EX_XLEN-1:0]  b,
    output logic [`RV_EX_XLEN-1:0]  result,
    output logic                    zero
);
    import rv_ex_pkg::*;

    logic [4:0] shamt;          // RV32I shifts use only b[4:0]
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (ctrl)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`RV_EX_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`RV_EX_XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;   // Sign bit fills from the left
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;                      // Codes 10..15
        endcase
    end

    // Branch compare relies on this for BEQ/BNE
    assign zero = (result == '0);

    // Clocked by the owning stage; a valid instruction never carries an illegal code
    a_ctrl_legal: assert property (
        @(posedge execute.clk) disable iff (execute.rst)
        execute.ex_valid |-> (ctrl <= ALU_AND)
    ) else $error("alu: illegal ctrl %0d on a valid instruction", ctrl);

endmodule

// ==== src/rv_ex_pkg.sv ====
package rv_ex_pkg;

    // ALU operation select, codes 10..15 are illegal
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,   // Signed compare
        ALU_SLTU = 4'd4,   // Unsigned compare
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,   // Arithmetic shift
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_ctrl_t;

    // Instruction class, picks the ALU operand pair
    typedef enum logic [2:0] {
        CLS_LDST   = 3'b000,   // rs1 + imm address
        CLS_BRANCH = 3'b001,   // rs1 vs rs2
        CLS_RI     = 3'b010,
        CLS_JAL    = 3'b011,
        CLS_LUI    = 3'b100,
        CLS_AUIPC  = 3'b101,
        CLS_JALR   = 3'b111    // 3'b110 left unused
    } op_class_t;

    // Forwarding source for one operand
    typedef enum logic [1:0] {
        FWD_RF     = 2'd0,   // Value read from the register file
        FWD_EXMEM  = 2'd1,   // Newest result, one stage ahead
        FWD_MEMWB  = 2'd2,
        FWD_WRPORT = 2'd3    // Register file write port, same cycle
    } fwd_sel_t;

endpackage

// ==== src/rv_ex_settings.svh ====
`ifndef RV_EX_SETTINGS_SVH
`define RV_EX_SETTINGS_SVH

// Datapath width
`define RV_EX_XLEN 32

// Register address width, x0..x31
`define RV_EX_RADDR_W 5

// x0 is hardwired to zero, never a forwarding target
`define RV_EX_ZERO_REG 5'd0

`endif
